/* common/audio_pkg.sv */
`default_nettype none

package audio_pkg;

  // ==================================================
  // Widths that carry a meaning
  // ==================================================

  // Word address into the flash
  typedef logic [22:0] flash_addr_t;

  // One flash read word, two 16-bit halves
  typedef logic [31:0] flash_word_t;

  // Audio sample sent to the output side
  typedef logic [7:0] sample_t;

  // Sample period, counted in CLK_50M cycles
  typedef logic [15:0] period_t;

  // ==================================================
  // Rate constants
  // ==================================================

  // 50 MHz over roughly 44 kHz
  localparam period_t PERIOD_DEFAULT = 16'd1136;

  // Change per faster or slower event
  localparam period_t PERIOD_STEP = 16'd64;

  // Fastest and slowest playback
  localparam period_t PERIOD_MIN = 16'd128;
  localparam period_t PERIOD_MAX = 16'd4096;

endpackage

`default_nettype wire

/* src/rate_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rate_ctrl (
  input  wire                  CLK_50M,
  input  wire                  arst_n,
  input  wire                  faster,
  input  wire                  slower,
  input  wire                  rate_reset,
  output audio_pkg::period_t   period
);

  audio_pkg::period_t period_q;

  // Headroom checks before the step, so no wrap in 16 bits
  logic at_low_end;
  logic at_high_end;

  assign at_low_end  = period_q < (audio_pkg::PERIOD_MIN + audio_pkg::PERIOD_STEP);
  assign at_high_end = period_q > (audio_pkg::PERIOD_MAX - audio_pkg::PERIOD_STEP);

  // Reset event beats faster, faster beats slower
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      period_q <= audio_pkg::PERIOD_DEFAULT;
    end
    else if (rate_reset)
    begin
      period_q <= audio_pkg::PERIOD_DEFAULT;
    end
    else if (faster)
    begin
      if (at_low_end)
        period_q <= audio_pkg::PERIOD_MIN;
      else
        period_q <= period_q - audio_pkg::PERIOD_STEP;
    end
    else if (slower)
    begin
      if (at_high_end)
        period_q <= audio_pkg::PERIOD_MAX;
      else
        period_q <= period_q + audio_pkg::PERIOD_STEP;
    end
  end

  assign period = period_q;

  // Timer relies on this range for its tick spacing
  a_period_in_range: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    (period >= audio_pkg::PERIOD_MIN) && (period <= audio_pkg::PERIOD_MAX)
  );

endmodule

`default_nettype wire

/* src/sample_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_timer (
  input  wire                  CLK_50M,
  input  wire                  arst_n,
  input  audio_pkg::period_t   period,
  output logic                 sample_tick
);

  // Cycles left until the next tick
  audio_pkg::period_t count_q;

  // Down-counter, reloaded with the period in force at the tick
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count_q <= audio_pkg::PERIOD_DEFAULT - 16'd1;
    end
    else if (count_q == '0)
    begin
      count_q <= period - 16'd1;
    end
    else
    begin
      count_q <= count_q - 16'd1;
    end
  end

  // Tick in the last cycle of each count
  assign sample_tick = (count_q == '0);

  // Unpacker must see each tick once
  a_tick_single: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    sample_tick |=> !sample_tick
  );

endmodule

`default_nettype wire

/* flash_player/flash_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module flash_reader #(
  parameter audio_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  wire                     CLK_50M,
  input  wire                     arst_n,
  output logic                    flash_read,
  output audio_pkg::flash_addr_t  flash_addr,
  input  wire                     flash_waitrequest,
  input  audio_pkg::flash_word_t  flash_readdata,
  input  wire                     flash_readdatavalid,
  output audio_pkg::flash_word_t  word,
  output logic                    word_valid,
  input  wire                     word_take
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_DATA,
    ST_HOLD
  } state_t;

  state_t                 state_q;
  audio_pkg::flash_addr_t addr_q;
  audio_pkg::flash_word_t word_q;
  audio_pkg::flash_word_t pend_q;
  logic                   word_valid_q;

  logic slot_free;
  logic load_from_flash;
  logic load_from_pend;
  logic park;

  // ==================================================
  // Output slot bookkeeping
  // ==================================================

  // Slot can take a new word in the same cycle it is consumed
  assign slot_free       = !word_valid_q || word_take;
  assign load_from_flash = (state_q == ST_WAIT_DATA) && flash_readdatavalid && slot_free;
  assign load_from_pend  = (state_q == ST_HOLD) && slot_free;
  assign park            = (state_q == ST_WAIT_DATA) && flash_readdatavalid && !slot_free;

  // ==================================================
  // Fetch FSM
  // ==================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q      <= ST_IDLE;
      addr_q       <= '0;
      word_valid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          state_q <= ST_REQUEST;
        end
        ST_REQUEST:
        begin
          // Accepted once waitrequest drops
          if (!flash_waitrequest)
          begin
            state_q <= ST_WAIT_DATA;
            if (addr_q == LAST_ADDR)
              addr_q <= '0;
            else
              addr_q <= addr_q + 23'd1;
          end
        end
        ST_WAIT_DATA:
        begin
          if (flash_readdatavalid)
            state_q <= slot_free ? ST_REQUEST : ST_HOLD;
        end
        ST_HOLD:
        begin
          // Prefetched word parked until the slot empties
          if (slot_free)
            state_q <= ST_REQUEST;
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase

      if (load_from_flash || load_from_pend)
        word_valid_q <= 1'b1;
      else if (word_take)
        word_valid_q <= 1'b0;
    end
  end

  // Data registers
  always_ff @(posedge CLK_50M)
  begin
    if (load_from_flash)
      word_q <= flash_readdata;
    else if (load_from_pend)
      word_q <= pend_q;

    if (park)
      pend_q <= flash_readdata;
  end

  assign flash_read = (state_q == ST_REQUEST);
  assign flash_addr = addr_q;
  assign word       = word_q;
  assign word_valid = word_valid_q;

  // Address and read held while the flash stalls the request
  a_addr_stable: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_addr))
  );

endmodule

`default_nettype wire

/* flash_player/sample_unpack.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_unpack (
  input  wire                     CLK_50M,
  input  wire                     arst_n,
  input  wire                     sample_tick,
  input  audio_pkg::flash_word_t  word,
  input  wire                     word_valid,
  output logic                    word_take,
  output audio_pkg::sample_t      sample,
  output logic                    sample_valid,
  output logic                    underrun
);

  // Low half plays first, high half second
  logic               half_q;
  logic               take_q;
  logic               valid_q;
  logic               underrun_q;
  audio_pkg::sample_t sample_q;

  logic play;
  logic starve;

  assign play   = sample_tick && word_valid;
  assign starve = sample_tick && !word_valid;

  // ==================================================
  // Control flags
  // ==================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      half_q     <= 1'b0;
      take_q     <= 1'b0;
      valid_q    <= 1'b0;
      underrun_q <= 1'b0;
    end
    else
    begin
      valid_q    <= play;
      underrun_q <= starve;
      // Word released along with its second sample
      take_q     <= play && half_q;
      // Half only advances when a sample actually played
      if (play)
        half_q <= !half_q;
    end
  end

  // Upper byte of the selected 16-bit half
  always_ff @(posedge CLK_50M)
  begin
    if (play)
    begin
      if (half_q)
        sample_q <= word[31:24];
      else
        sample_q <= word[15:8];
    end
  end

  assign word_take    = take_q;
  assign sample       = sample_q;
  assign sample_valid = valid_q;
  assign underrun     = underrun_q;

endmodule

`default_nettype wire

/* src/audio_player_top.sv */
`timescale 1ns/100ps
`default_nettype none

module audio_player_top #(
  parameter audio_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  wire                     CLK_50M,
  input  wire                     arst_n,
  input  wire                     faster,
  input  wire                     slower,
  input  wire                     rate_reset,
  output logic                    flash_read,
  output audio_pkg::flash_addr_t  flash_addr,
  input  wire                     flash_waitrequest,
  input  audio_pkg::flash_word_t  flash_readdata,
  input  wire                     flash_readdatavalid,
  output audio_pkg::sample_t      sample,
  output logic                    sample_valid,
  output logic                    underrun,
  output audio_pkg::period_t      period
);

  logic                   sample_tick;
  audio_pkg::flash_word_t word;
  logic                   word_valid;
  logic                   word_take;

  // ==================================================
  // Input side
  // ==================================================

  rate_ctrl i_rate_ctrl (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .faster     (faster),
    .slower     (slower),
    .rate_reset (rate_reset),
    .period     (period)
  );

  sample_timer i_sample_timer (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .period      (period),
    .sample_tick (sample_tick)
  );

  // ==================================================
  // Flash fetch and output side
  // ==================================================

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) i_flash_reader (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .word                (word),
    .word_valid          (word_valid),
    .word_take           (word_take)
  );

  sample_unpack i_sample_unpack (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample_tick  (sample_tick),
    .word         (word),
    .word_valid   (word_valid),
    .word_take    (word_take),
    .sample       (sample),
    .sample_valid (sample_valid),
    .underrun     (underrun)
  );

endmodule

`default_nettype wire

/* bench/flash_model.sv */
`timescale 1ns/100ps
`default_nettype none

module flash_model (
  input  wire                     CLK_50M,
  input  wire                     arst_n,
  input  wire [31:0]              rnd,
  input  wire                     long_stall,
  input  wire                     read,
  input  audio_pkg::flash_addr_t  addr,
  output logic                    waitrequest,
  output audio_pkg::flash_word_t  readdata,
  output logic                    readdatavalid
);

  // Stall cycles left for the request on the bus
  logic [9:0]             wait_left;
  logic [63:0]            cyc;
  logic [63:0]            due_next;
  logic [63:0]            due_q[$];
  audio_pkg::flash_word_t data_q[$];

  // Content of the recording, scrambled over the whole address
  function automatic audio_pkg::flash_word_t word_for_addr(input audio_pkg::flash_addr_t a);
    logic [31:0] x;
    x = {9'd0, a};
    return (x * 32'h9E37_79B1) ^ {x[15:0], x[22:7]} ^ 32'h5A5A_C3C3;
  endfunction

  // 0 to 6 cycles normally, a few hundred when stalling
  function automatic logic [9:0] pick_wait(input logic [31:0] r, input logic slow);
    if (slow)
      return 10'd200 + {1'b0, r[8:0]};
    return {7'd0, r[2:0]} % 10'd7;
  endfunction

  assign waitrequest = read && (wait_left != 10'd0);

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_left     <= 10'd0;
      cyc           <= 64'd0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
      due_q.delete();
      data_q.delete();
    end
    else
    begin
      cyc           <= cyc + 64'd1;
      readdatavalid <= 1'b0;
      // Oldest response first
      if (due_q.size() != 0 && due_q[0] <= cyc)
      begin
        readdatavalid <= 1'b1;
        readdata      <= data_q[0];
        due_q.delete(0);
        data_q.delete(0);
      end
      if (read && wait_left != 10'd0)
      begin
        wait_left <= wait_left - 10'd1;
      end
      else if (read)
      begin
        // Latency 1 to 8, never overtaking an earlier response
        due_next = cyc + {61'd0, rnd[13:11]} + 64'd1;
        if (due_q.size() != 0 && due_next <= due_q[$])
          due_next = due_q[$] + 64'd1;
        due_q.push_back(due_next);
        data_q.push_back(word_for_addr(addr));
        wait_left <= pick_wait(rnd, long_stall);
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_audio_player.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_audio_player;

  localparam audio_pkg::flash_addr_t LAST_ADDR = 23'd15;
  localparam int SAMPLES_FREE  = 40;
  localparam int SAMPLES_TOTAL = 80;
  localparam int HALF_CLK_NS   = 10;
  // Every sample at the slowest rate, plus room for reset and stalls
  localparam int WATCHDOG_NS   = SAMPLES_TOTAL * int'(audio_pkg::PERIOD_MAX) * 20 + 500000;

  logic                   CLK_50M;
  logic                   arst_n;
  logic                   faster;
  logic                   slower;
  logic                   rate_reset;
  logic                   flash_read;
  audio_pkg::flash_addr_t flash_addr;
  logic                   flash_waitrequest;
  audio_pkg::flash_word_t flash_readdata;
  logic                   flash_readdatavalid;
  audio_pkg::sample_t     sample;
  logic                   sample_valid;
  logic                   underrun;
  audio_pkg::period_t     period;
  logic [31:0]            flash_rnd;
  logic                   long_stall;

  // Reference model state
  logic [31:0]            rng_state;
  int                     error_count;
  int                     check_count;
  int                     samples_seen;
  int                     underrun_count;
  int                     wrap_count;
  logic [63:0]            cycle;
  logic [63:0]            next_tick_event;
  audio_pkg::period_t     exp_period;
  audio_pkg::period_t     last_period;
  audio_pkg::flash_addr_t exp_play_addr;
  audio_pkg::flash_addr_t exp_fetch_addr;
  audio_pkg::flash_addr_t prev_addr;
  logic                   exp_half;
  logic                   prev_stalled;

  audio_player_top #(
    .LAST_ADDR (LAST_ADDR)
  ) i_dut (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .faster              (faster),
    .slower              (slower),
    .rate_reset          (rate_reset),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .underrun            (underrun),
    .period              (period)
  );

  flash_model i_flash (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .rnd           (flash_rnd),
    .long_stall    (long_stall),
    .read          (flash_read),
    .addr          (flash_addr),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  // ==================================================
  // Helpers
  // ==================================================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Same recording content as the flash model holds
  function automatic audio_pkg::flash_word_t expected_word(input audio_pkg::flash_addr_t a);
    logic [31:0] x;
    x = {9'd0, a};
    return (x * 32'h9E37_79B1) ^ {x[15:0], x[22:7]} ^ 32'h5A5A_C3C3;
  endfunction

  // Reset first, then faster, then slower, clamped to the rate limits
  function automatic audio_pkg::period_t next_period(input audio_pkg::period_t p,
                                                     input logic f, input logic s,
                                                     input logic r);
    int v;
    v = int'(p);
    if (r)
      v = int'(audio_pkg::PERIOD_DEFAULT);
    else if (f)
      v = v - int'(audio_pkg::PERIOD_STEP);
    else if (s)
      v = v + int'(audio_pkg::PERIOD_STEP);
    if (v < int'(audio_pkg::PERIOD_MIN))
      v = int'(audio_pkg::PERIOD_MIN);
    if (v > int'(audio_pkg::PERIOD_MAX))
      v = int'(audio_pkg::PERIOD_MAX);
    return v[15:0];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("** Error at %0t: %s", $time, what);
  endtask

  // Check the DUT outputs of one cycle and drive the next inputs
  task automatic run_cycle(input logic random_rates, input logic force_faster);
    logic [31:0]            r;
    audio_pkg::flash_word_t w;
    audio_pkg::sample_t     exp_sample;
    @(negedge CLK_50M);
    cycle++;
    // Events driven one cycle ago are in the period register now
    exp_period = next_period(exp_period, faster, slower, rate_reset);
    compare_value("period", 32'(period), 32'(exp_period));

    if (prev_stalled)
    begin
      compare_value("flash_read", 32'(flash_read), 32'd1);
      compare_value("flash_addr", 32'(flash_addr), 32'(prev_addr));
    end
    if (flash_read && !flash_waitrequest)
    begin
      compare_value("flash_addr", 32'(flash_addr), 32'(exp_fetch_addr));
      exp_fetch_addr = (exp_fetch_addr == LAST_ADDR) ? '0 : exp_fetch_addr + 23'd1;
    end
    prev_stalled = flash_read && flash_waitrequest;
    prev_addr    = flash_addr;

    if (sample_valid && underrun)
      report_failure("sample_valid and underrun pulsed in the same cycle");
    // Each tick shows up one cycle later as a sample or an underrun
    if (sample_valid || underrun)
    begin
      compare_value("sample_tick cycle", 32'(cycle), 32'(next_tick_event));
      next_tick_event = cycle + {48'd0, last_period};
    end
    if (sample_valid)
    begin
      w          = expected_word(exp_play_addr);
      exp_sample = exp_half ? w[31:24] : w[15:8];
      compare_value("sample", 32'(sample), 32'(exp_sample));
      samples_seen++;
      if (exp_half)
      begin
        if (exp_play_addr == LAST_ADDR)
        begin
          exp_play_addr = '0;
          wrap_count++;
        end
        else
        begin
          exp_play_addr = exp_play_addr + 23'd1;
        end
      end
      exp_half = !exp_half;
    end
    if (underrun)
      underrun_count++;
    last_period = exp_period;

    rng_state  = xorshift(rng_state);
    flash_rnd  = rng_state;
    faster     = 1'b0;
    slower     = 1'b0;
    rate_reset = 1'b0;
    if (random_rates)
    begin
      rng_state = xorshift(rng_state);
      r         = rng_state;
      // Roughly one event per sample period, sometimes several at once
      if (r[9:0] == 10'd0)
      begin
        faster     = r[12];
        slower     = r[13];
        rate_reset = (r[15:14] == 2'd0);
        if (!(faster || slower || rate_reset))
          slower = 1'b1;
      end
    end
    if (force_faster)
      faster = 1'b1;
  endtask

  // ==================================================
  // Clock, watchdog and test sequence
  // ==================================================

  initial
  begin
    CLK_50M = 1'b0;
    forever #(HALF_CLK_NS) CLK_50M = ~CLK_50M;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, playback stopped making progress", $time);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    arst_n          = 1'b0;
    faster          = 1'b0;
    slower          = 1'b0;
    rate_reset      = 1'b0;
    flash_rnd       = 32'd0;
    long_stall      = 1'b0;
    rng_state       = 32'h3fef57bc;
    error_count     = 0;
    check_count     = 0;
    samples_seen    = 0;
    underrun_count  = 0;
    wrap_count      = 0;
    cycle           = 64'd0;
    next_tick_event = {48'd0, audio_pkg::PERIOD_DEFAULT};
    exp_period      = audio_pkg::PERIOD_DEFAULT;
    last_period     = audio_pkg::PERIOD_DEFAULT;
    exp_play_addr   = '0;
    exp_fetch_addr  = '0;
    prev_addr       = '0;
    exp_half        = 1'b0;
    prev_stalled    = 1'b0;

    repeat (2)
    begin
      @(negedge CLK_50M);
      compare_value("period", 32'(period), 32'(audio_pkg::PERIOD_DEFAULT));
      compare_value("sample_valid", 32'(sample_valid), 32'd0);
      compare_value("underrun", 32'(underrun), 32'd0);
      compare_value("flash_read", 32'(flash_read), 32'd0);
    end
    arst_n = 1'b1;

    // Normal playback with random rate events
    while (samples_seen < SAMPLES_FREE)
      run_cycle(1'b1, 1'b0);

    // Fastest rate against a slow flash
    long_stall = 1'b1;
    repeat (64)
      run_cycle(1'b0, 1'b1);
    compare_value("period", 32'(period), 32'(audio_pkg::PERIOD_MIN));
    while (samples_seen < SAMPLES_TOTAL)
      run_cycle(1'b0, 1'b0);

    if (wrap_count == 0)
      report_failure("playback never wrapped past the last address");
    if (underrun_count == 0)
      report_failure("the stall phase produced no underrun");

    $display("Checks: %0d  errors: %0d  samples: %0d  underruns: %0d  wraps: %0d",
             check_count, error_count, samples_seen, underrun_count, wrap_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/audio_pkg.sv
src/rate_ctrl.sv
src/sample_timer.sv
flash_player/flash_reader.sv
flash_player/sample_unpack.sv
src/audio_player_top.sv
bench/flash_model.sv
bench/tb_audio_player.sv

/* Makefile */
# Verilator flow for the flash audio player

VERILATOR ?= verilator
TOP       ?= tb_audio_player
RTL_TOP   ?= audio_player_top
FLAGS     ?= --timing --assert
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f

RTL_FILES = common/audio_pkg.sv \
            src/rate_ctrl.sv \
            src/sample_timer.sv \
            flash_player/flash_reader.sv \
            flash_player/sample_unpack.sv \
            src/audio_player_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(BUILD_DIR)
